/* imuldiv_top.f */
source/imuldiv_pkg.sv
source/imuldiv_div_ctrl_if.sv
source/imuldiv_div_dpath.sv
source/imuldiv_div_ctrl.sv
source/imuldiv_int_div_iterative.sv
source/imuldiv_int_mul_iterative.sv
source/imuldiv_top.sv
sim/imuldiv_tb.sv

/* sim/imuldiv_tb.sv */
/* directed testbench for the multiply/divide unit: runs divide, multiply,
   latency and back-pressure tests against a reference model */
`timescale 1ns/10ps

module imuldiv_tb;

  localparam int width = 32;

  // upper bound on requests issued by all tests together
  localparam int num_ops        = 130;
  localparam int max_stall      = 10;
  localparam int timeout_cycles = num_ops * (34 + max_stall) + 100;

  localparam logic [width-1:0] min_val = {1'b1, {(width-1){1'b0}}};
  localparam logic [width-1:0] max_val = {1'b0, {(width-1){1'b1}}};

  logic                    clk = 1'b0;
  logic                    reset;
  imuldiv_pkg::muldiv_fn_e req_fn;
  logic [width-1:0]        req_a;
  logic [width-1:0]        req_b;
  logic                    req_val;
  logic                    req_rdy;
  logic [2*width-1:0]      resp_result;
  logic                    resp_val;
  logic                    resp_rdy;

  int cycle_count = 0;

  // 40 ns period
  always #20 clk = ~clk;

  imuldiv_top #(.width(width)) u_imuldiv_top (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > timeout_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display(">>> FAIL");
      $fatal(1, "run stopped on timeout");
    end
  end

  // ----------------------------------------------------------
  // checking and reference model
  // ----------------------------------------------------------

  task automatic check(input string name, input logic [2*width-1:0] got,
                       input logic [2*width-1:0] exp);
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // remainder high, quotient low for divides; full product for multiply
  function automatic logic [2*width-1:0] expected_result(
    input imuldiv_pkg::muldiv_fn_e fn, input logic [width-1:0] a,
    input logic [width-1:0] b);
    logic signed [2*width-1:0] sa;
    logic signed [2*width-1:0] sb;
    logic [width-1:0]          am;
    logic [width-1:0]          bm;
    logic [width-1:0]          q;
    logic [width-1:0]          r;
    logic                      an;
    logic                      bn;
    if (!imuldiv_pkg::is_div_fn(fn)) begin
      sa = {{width{a[width-1]}}, a};
      sb = {{width{b[width-1]}}, b};
      return sa * sb;
    end
    // sign bits matter only for the signed divide
    an = (fn == imuldiv_pkg::DIV) && a[width-1];
    bn = (fn == imuldiv_pkg::DIV) && b[width-1];
    am = an ? -a : a;
    bm = bn ? -b : b;
    if (bm == '0) begin
      q = '1;
      r = am;
    end else begin
      q = am / bm;
      r = am % bm;
    end
    if (an ^ bn) q = -q;
    if (an) r = -r;
    return {r, q};
  endfunction

  // ----------------------------------------------------------
  // one request and its response
  // ----------------------------------------------------------

  // starts and ends a couple of ns after a rising edge
  // the response stays pending until the next request takes its edge
  task automatic do_op(input imuldiv_pkg::muldiv_fn_e fn, input logic [width-1:0] a,
                       input logic [width-1:0] b, input int stall);
    logic [2*width-1:0] exp;
    int                 lat;
    int                 exp_lat;
    exp     = expected_result(fn, a, b);
    exp_lat = imuldiv_pkg::is_div_fn(fn) ? width + 2 : width + 1;
    req_fn   = fn;
    req_a    = a;
    req_b    = b;
    req_val  = 1'b1;
    // any pending response leaves on the same edge
    resp_rdy = 1'b1;
    // let req_rdy settle on the new code
    #1;
    check("req_rdy", req_rdy, 1);
    // accepting edge
    @(posedge clk);
    #2;
    req_val  = 1'b0;
    resp_rdy = (stall == 0);
    lat      = 0;
    while (!resp_val) begin
      check("req_rdy", req_rdy, 0);
      @(posedge clk);
      #2;
      lat++;
    end
    check("resp latency", lat, exp_lat);
    check("resp_result", resp_result, exp);
    // stalled response must hold, no new request taken
    repeat (stall) begin
      @(posedge clk);
      #2;
      check("resp_val", resp_val, 1);
      check("resp_result", resp_result, exp);
      check("req_rdy", req_rdy, 0);
    end
  endtask

  // take the final response and let the port go quiet
  task automatic release_last;
    resp_rdy = 1'b1;
    @(posedge clk);
    #2;
    check("resp_val", resp_val, 0);
    check("req_rdy", req_rdy, 1);
  endtask

  // ----------------------------------------------------------
  // tests
  // ----------------------------------------------------------

  task automatic idle_ready(input imuldiv_pkg::muldiv_fn_e fn);
    req_fn = fn;
    #1;
    check("req_rdy", req_rdy, 1);
    check("resp_val", resp_val, 0);
    // back onto the drive point
    @(posedge clk);
    #2;
  endtask

  task automatic idle_after_reset;
    idle_ready(imuldiv_pkg::MUL);
    idle_ready(imuldiv_pkg::DIV);
    idle_ready(imuldiv_pkg::DIVU);
  endtask

  task automatic unsigned_divides;
    do_op(imuldiv_pkg::DIVU, 32'hffff_ffff, 32'd1, 0);
    do_op(imuldiv_pkg::DIVU, 32'hffff_fffe, 32'd1, 0);
    do_op(imuldiv_pkg::DIVU, min_val, 32'd1, 0);
    do_op(imuldiv_pkg::DIVU, 32'hffff_ffff, 32'd7, 0);
    do_op(imuldiv_pkg::DIVU, 32'd100, 32'd7, 0);
    do_op(imuldiv_pkg::DIVU, 32'hdead_beef, 32'h0000_1234, 0);
    do_op(imuldiv_pkg::DIVU, 32'd5, 32'd0, 0);
    for (int i = 0; i < 40; i++) begin
      do_op(imuldiv_pkg::DIVU, $urandom, $urandom, 0);
    end
  endtask

  task automatic signed_divides;
    // all four sign combinations
    do_op(imuldiv_pkg::DIV, 100, 7, 0);
    do_op(imuldiv_pkg::DIV, -100, 7, 0);
    do_op(imuldiv_pkg::DIV, 100, -7, 0);
    do_op(imuldiv_pkg::DIV, -100, -7, 0);
    // divide by zero, both dividend signs
    do_op(imuldiv_pkg::DIV, 7, 0, 0);
    do_op(imuldiv_pkg::DIV, -7, 0, 0);
    // overflow corner and its neighbours
    do_op(imuldiv_pkg::DIV, min_val, -1, 0);
    do_op(imuldiv_pkg::DIV, min_val, 1, 0);
    do_op(imuldiv_pkg::DIV, -1, min_val, 0);
  endtask

  task automatic signed_multiplies;
    do_op(imuldiv_pkg::MUL, 3, 5, 0);
    do_op(imuldiv_pkg::MUL, -3, 5, 0);
    do_op(imuldiv_pkg::MUL, 3, -5, 0);
    do_op(imuldiv_pkg::MUL, -3, -5, 0);
    do_op(imuldiv_pkg::MUL, 0, 32'h1234_5678, 0);
    do_op(imuldiv_pkg::MUL, -1, 0, 0);
    do_op(imuldiv_pkg::MUL, min_val, min_val, 0);
    do_op(imuldiv_pkg::MUL, max_val, max_val, 0);
    do_op(imuldiv_pkg::MUL, min_val, max_val, 0);
    do_op(imuldiv_pkg::MUL, -1, -1, 0);
    for (int i = 0; i < 40; i++) begin
      do_op(imuldiv_pkg::MUL, $urandom, $urandom, 0);
    end
  endtask

  // mixed codes, random stall on the response side
  task automatic mixed_backpressure;
    imuldiv_pkg::muldiv_fn_e fn;
    int                      stall;
    for (int i = 0; i < 24; i++) begin
      fn    = imuldiv_pkg::muldiv_fn_e'($urandom % 3);
      stall = $urandom % (max_stall + 1);
      do_op(fn, $urandom, $urandom, stall);
    end
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin
    reset    = 1'b1;
    req_fn   = imuldiv_pkg::MUL;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    void'($urandom(79824));
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    idle_after_reset;
    unsigned_divides;
    signed_divides;
    signed_multiplies;
    mixed_backpressure;
    release_last;
    $display(">>> PASS");
    $finish;
  end

endmodule

/* source/imuldiv_div_ctrl.sv */
/* divider FSM: accepts a request, runs the load, iteration and sign-fix
   cycles, then holds the response until it is taken */
`timescale 1ns/10ps

module imuldiv_div_ctrl #(
  parameter int width = 32
) (
  input  logic     clk,
  input  logic     reset,

  input  logic     divreq_val,
  output logic     divreq_rdy,
  output logic     divresp_val,
  input  logic     divresp_rdy,

  div_ctrl_if.ctrl ctrl
);

  localparam int cnt_w = $clog2(width + 1);

  typedef enum logic [1:0] {
    state_idle,
    state_calc,
    state_fix,
    state_done
  } state_e;

  state_e           state;
  state_e           state_next;
  logic [cnt_w-1:0] cnt;
  logic             accept;
  logic             last_iter;

  // ----------------------------------------------------------
  // handshake and enables
  // ----------------------------------------------------------

  // a new request may arrive on the edge that takes the response
  assign divreq_rdy  = (state == state_idle) || ((state == state_done) && divresp_rdy);
  assign divresp_val = (state == state_done);
  assign accept      = divreq_val && divreq_rdy;
  assign last_iter   = (cnt == cnt_w'(width));

  // count 0 is the load cycle, 1..width are the iterations
  assign ctrl.load   = accept;
  assign ctrl.b_en   = (state == state_calc) && (cnt == '0);
  assign ctrl.a_en   = (state == state_calc) && (cnt != '0);
  assign ctrl.fix_en = (state == state_fix);

  always_comb begin
    state_next = state;
    case (state)
      state_idle: if (accept) state_next = state_calc;
      state_calc: if (last_iter) state_next = state_fix;
      state_fix:  state_next = state_done;
      state_done: begin
        if (accept) begin
          state_next = state_calc;
        end else if (divresp_rdy) begin
          state_next = state_idle;
        end
      end
      default:    state_next = state_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= state_idle;
      cnt   <= '0;
    end else begin
      state <= state_next;
      if (accept) begin
        cnt <= '0;
      end else if ((state == state_calc) && !last_iter) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // iterations only while calculating, with a known subtract sign
  a_en_in_calc: assert property (
    @(posedge clk) disable iff (reset)
    ctrl.a_en |-> (state == state_calc) && !$isunknown(ctrl.sub_neg)
  );

  cnt_in_range: assert property (
    @(posedge clk) disable iff (reset)
    cnt <= cnt_w'(width)
  );

endmodule

/* source/imuldiv_div_ctrl_if.sv */
/* control and status bundle between the divider FSM and the divider datapath,
   one instance per divider block */
`timescale 1ns/10ps

interface div_ctrl_if #(
  parameter int width = 32
);

  // from the FSM
  // latch request operands and signedness
  logic load;
  // one shift-subtract step
  logic a_en;
  // divisor magnitude and initial remainder/quotient
  logic b_en;
  // register the sign-corrected result
  logic fix_en;

  // from the datapath, sign of the trial subtraction
  logic sub_neg;

  modport ctrl (output load, a_en, b_en, fix_en, input sub_neg);
  modport dpath (input load, a_en, b_en, fix_en, output sub_neg);

  // narrower operands are not covered by the divider
  if (width < 8) begin : g_width_check
    $error("div_ctrl_if: operand width must be 8 or more");
  end

endinterface

/* source/imuldiv_div_dpath.sv */
/* restoring divider datapath: operand unsigning, one shift-subtract step per
   cycle, then sign correction into the result register */
`timescale 1ns/10ps

module imuldiv_div_dpath #(
  parameter int width = 32
) (
  input  logic               clk,
  input  logic               reset,

  input  logic               divreq_signed,
  input  logic [width-1:0]   divreq_a,
  input  logic [width-1:0]   divreq_b,

  output logic [2*width-1:0] divresp_result,

  div_ctrl_if.dpath          ctrl
);

  // raw request operands, held for the whole operation
  logic               signed_reg;
  logic [width-1:0]   a_reg;
  logic [width-1:0]   b_reg;

  // working registers
  logic [width-1:0]   b_mag_reg;
  logic [2*width-1:0] rq_reg;
  logic [2*width-1:0] result_reg;

  logic               a_neg;
  logic               b_neg;
  logic [width-1:0]   a_mag;
  logic [width-1:0]   b_mag;
  logic [2*width:0]   shifted;
  logic [width+1:0]   diff;
  logic [2*width-1:0] step;
  logic [width-1:0]   quo;
  logic [width-1:0]   rem;
  logic [width-1:0]   quo_fix;
  logic [width-1:0]   rem_fix;

  // ----------------------------------------------------------
  // operand unsigning
  // ----------------------------------------------------------

  // sign bits only count for a signed divide
  assign a_neg = signed_reg && a_reg[width-1];
  assign b_neg = signed_reg && b_reg[width-1];

  assign a_mag = a_neg ? -a_reg : a_reg;
  assign b_mag = b_neg ? -b_reg : b_reg;

  // ----------------------------------------------------------
  // shift-subtract step
  // ----------------------------------------------------------

  // remainder in upper half, quotient bits fill from the bottom
  assign shifted = {rq_reg, 1'b0};

  // extra top bit so the borrow shows as the sign
  assign diff = {1'b0, shifted[2*width:width]} - {2'b00, b_mag_reg};
  assign ctrl.sub_neg = diff[width+1];

  // negative: restore, keep quotient bit 0
  // otherwise take the difference and set the quotient bit
  assign step = ctrl.sub_neg ? shifted[2*width-1:0]
                             : {diff[width-1:0], shifted[width-1:1], 1'b1};

  // ----------------------------------------------------------
  // sign fix
  // ----------------------------------------------------------

  assign quo = rq_reg[width-1:0];
  assign rem = rq_reg[2*width-1:width];

  // quotient negative when signs differ, remainder follows dividend
  assign quo_fix = (a_neg ^ b_neg) ? -quo : quo;
  assign rem_fix = a_neg ? -rem : rem;

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      signed_reg <= divreq_signed;
      a_reg      <= divreq_a;
      b_reg      <= divreq_b;
    end
    if (ctrl.b_en) begin
      b_mag_reg <= b_mag;
      rq_reg    <= {{width{1'b0}}, a_mag};
    end else if (ctrl.a_en) begin
      rq_reg <= step;
    end
    if (ctrl.fix_en) begin
      result_reg <= {rem_fix, quo_fix};
    end
  end

  assign divresp_result = result_reg;

  // partial remainder stays below a nonzero divisor over all iterations
  rem_below_divisor: assert property (
    @(posedge clk) disable iff (reset)
    (ctrl.a_en && (b_mag_reg != '0)) |-> (rem < b_mag_reg)
  );

endmodule

/* source/imuldiv_int_div_iterative.sv */
/* iterative divider block, FSM and datapath joined by the control bundle;
   request and response use valid/ready handshakes */
`timescale 1ns/10ps

module imuldiv_int_div_iterative #(
  parameter int width = 32
) (
  input  logic               clk,
  input  logic               reset,

  input  logic               divreq_signed,
  input  logic [width-1:0]   divreq_a,
  input  logic [width-1:0]   divreq_b,
  input  logic               divreq_val,
  output logic               divreq_rdy,

  output logic [2*width-1:0] divresp_result,
  output logic               divresp_val,
  input  logic               divresp_rdy
);

  // enables down, subtract sign up
  div_ctrl_if #(.width(width)) ctrl_if ();

  imuldiv_div_dpath #(.width(width)) u_dpath (
    .clk            (clk),
    .reset          (reset),
    .divreq_signed  (divreq_signed),
    .divreq_a       (divreq_a),
    .divreq_b       (divreq_b),
    .divresp_result (divresp_result),
    .ctrl           (ctrl_if.dpath)
  );

  imuldiv_div_ctrl #(.width(width)) u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .divreq_val  (divreq_val),
    .divreq_rdy  (divreq_rdy),
    .divresp_val (divresp_val),
    .divresp_rdy (divresp_rdy),
    .ctrl        (ctrl_if.ctrl)
  );

endmodule

/* source/imuldiv_int_mul_iterative.sv */
/* iterative signed multiplier, one add-and-shift per cycle on magnitudes,
   product negated on the last step when operand signs differ */
`timescale 1ns/10ps

module imuldiv_int_mul_iterative #(
  parameter int width = 32
) (
  input  logic               clk,
  input  logic               reset,

  input  logic [width-1:0]   mulreq_a,
  input  logic [width-1:0]   mulreq_b,
  input  logic               mulreq_val,
  output logic               mulreq_rdy,

  output logic [2*width-1:0] mulresp_result,
  output logic               mulresp_val,
  input  logic               mulresp_rdy
);

  localparam int cnt_w = $clog2(width);

  typedef enum logic [1:0] {
    state_idle,
    state_load,
    state_calc,
    state_done
  } state_e;

  state_e             state;
  logic [cnt_w-1:0]   cnt;
  logic               accept;
  logic               last_step;

  // raw operands, then working copies
  logic [width-1:0]   a_reg;
  logic [width-1:0]   b_reg;
  logic [width-1:0]   a_mag_reg;
  logic               neg_reg;
  logic [2*width-1:0] prod_reg;

  logic [width-1:0]   a_mag;
  logic [width-1:0]   b_mag;
  logic [width:0]     sum;
  logic [2*width-1:0] step;

  // ----------------------------------------------------------
  // handshake
  // ----------------------------------------------------------

  assign mulreq_rdy  = (state == state_idle) || ((state == state_done) && mulresp_rdy);
  assign mulresp_val = (state == state_done);
  assign accept      = mulreq_val && mulreq_rdy;
  assign last_step   = (cnt == cnt_w'(width - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= state_idle;
      cnt   <= '0;
    end else begin
      case (state)
        state_idle: if (accept) state <= state_load;
        state_load: begin
          state <= state_calc;
          cnt   <= '0;
        end
        state_calc: begin
          cnt <= cnt + 1'b1;
          if (last_step) state <= state_done;
        end
        state_done: begin
          if (accept) begin
            state <= state_load;
          end else if (mulresp_rdy) begin
            state <= state_idle;
          end
        end
        default:    state <= state_idle;
      endcase
    end
  end

  // ----------------------------------------------------------
  // add-and-shift datapath
  // ----------------------------------------------------------

  assign a_mag = a_reg[width-1] ? -a_reg : a_reg;
  assign b_mag = b_reg[width-1] ? -b_reg : b_reg;

  // multiplier bits sit in the low half and leave at bit 0
  assign sum  = {1'b0, prod_reg[2*width-1:width]}
              + (prod_reg[0] ? {1'b0, a_mag_reg} : {(width+1){1'b0}});
  assign step = {sum, prod_reg[width-1:1]};

  always_ff @(posedge clk) begin
    if (accept) begin
      a_reg <= mulreq_a;
      b_reg <= mulreq_b;
    end
    if (state == state_load) begin
      a_mag_reg <= a_mag;
      neg_reg   <= a_reg[width-1] ^ b_reg[width-1];
      prod_reg  <= {{width{1'b0}}, b_mag};
    end else if (state == state_calc) begin
      // final step applies the product sign
      prod_reg <= (last_step && neg_reg) ? -step : step;
    end
  end

  assign mulresp_result = prod_reg;

  // stalled response keeps its value
  hold_on_stall: assert property (
    @(posedge clk) disable iff (reset)
    (mulresp_val && !mulresp_rdy) |=> mulresp_val && $stable(mulresp_result)
  );

endmodule

/* source/imuldiv_pkg.sv */
/* shared function codes for the multiply/divide unit and small decode helpers,
   referenced by scoped name from the top level and the testbench */

package imuldiv_pkg;

  // ----------------------------------------------------------
  // function code
  // ----------------------------------------------------------

  // width of the request function field
  localparam int FN_W = 2;

  // operation select on the request port
  typedef enum logic [FN_W-1:0] {
    MUL  = 2'd0,
    DIV  = 2'd1,
    DIVU = 2'd2
  } muldiv_fn_e;

  // ----------------------------------------------------------
  // decode helpers
  // ----------------------------------------------------------

  // true when the code goes to the divider
  function automatic logic is_div_fn(muldiv_fn_e fn);
    return (fn == DIV) || (fn == DIVU);
  endfunction

  // signed divide only, unsigned divide and multiply give 0
  function automatic logic is_signed_div_fn(muldiv_fn_e fn);
    return (fn == DIV);
  endfunction

endpackage

/* source/imuldiv_top.sv */
/* multiply/divide unit top level: steers each request to the multiplier or
   the divider by function code, one operation in flight at a time */
`timescale 1ns/10ps

module imuldiv_top #(
  parameter int width = 32
) (
  input  logic                   clk,
  input  logic                   reset,

  input  imuldiv_pkg::muldiv_fn_e req_fn,
  input  logic [width-1:0]       req_a,
  input  logic [width-1:0]       req_b,
  input  logic                   req_val,
  output logic                   req_rdy,

  output logic [2*width-1:0]     resp_result,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  logic               sel_div;
  logic               busy;
  logic               open_slot;
  logic               req_fire;
  logic               resp_fire;

  logic               divreq_val;
  logic               divreq_rdy;
  logic [2*width-1:0] divresp_result;
  logic               divresp_val;
  logic               divresp_rdy;

  logic               mulreq_val;
  logic               mulreq_rdy;
  logic [2*width-1:0] mulresp_result;
  logic               mulresp_val;
  logic               mulresp_rdy;

  // ----------------------------------------------------------
  // response mux
  // ----------------------------------------------------------

  assign resp_val    = divresp_val || mulresp_val;
  assign resp_result = divresp_val ? divresp_result : mulresp_result;
  assign divresp_rdy = resp_rdy && divresp_val;
  assign mulresp_rdy = resp_rdy && mulresp_val;
  assign resp_fire   = resp_val && resp_rdy;

  // ----------------------------------------------------------
  // request steering
  // ----------------------------------------------------------

  assign sel_div = imuldiv_pkg::is_div_fn(req_fn);

  // free, or freed on this edge by the outgoing response
  assign open_slot  = !busy || resp_fire;
  assign divreq_val = req_val && sel_div && open_slot;
  assign mulreq_val = req_val && !sel_div && open_slot;
  assign req_rdy    = open_slot && (sel_div ? divreq_rdy : mulreq_rdy);
  assign req_fire   = req_val && req_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (req_fire) begin
      busy <= 1'b1;
    end else if (resp_fire) begin
      busy <= 1'b0;
    end
  end

  imuldiv_int_div_iterative #(.width(width)) u_div (
    .clk            (clk),
    .reset          (reset),
    .divreq_signed  (imuldiv_pkg::is_signed_div_fn(req_fn)),
    .divreq_a       (req_a),
    .divreq_b       (req_b),
    .divreq_val     (divreq_val),
    .divreq_rdy     (divreq_rdy),
    .divresp_result (divresp_result),
    .divresp_val    (divresp_val),
    .divresp_rdy    (divresp_rdy)
  );

  imuldiv_int_mul_iterative #(.width(width)) u_mul (
    .clk            (clk),
    .reset          (reset),
    .mulreq_a       (req_a),
    .mulreq_b       (req_b),
    .mulreq_val     (mulreq_val),
    .mulreq_rdy     (mulreq_rdy),
    .mulresp_result (mulresp_result),
    .mulresp_val    (mulresp_val),
    .mulresp_rdy    (mulresp_rdy)
  );

  // single operation in flight, so never two responses at once
  one_resp_at_a_time: assert property (
    @(posedge clk) disable iff (reset)
    !(divresp_val && mulresp_val)
  );

endmodule
